// File: rvPkg.sv
`default_nettype none

package rvPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluFn_e;

	// same codes the core's commit path already decodes
	typedef enum logic [2:0] {
		wbAlu   = 3'd0,
		wbLink  = 3'd1,
		wbUpper = 3'd3,
		wbAuipc = 3'd5,
		wbCsr   = 3'd6
	} wbSel_e;

	typedef struct packed {
		logic [31:0] opA;
		logic [31:0] opB;
		logic [4:0]  rd;
		logic        we;
		aluFn_e      aluFn;
		wbSel_e      wbSel;
		logic [31:0] imm;          // branch, jump, U-type or auipc immediate
		logic [31:0] pc;
		logic        isBranch;
		logic        branchNe;     // invert the zero test
		logic        jump;
		logic        jumpReg;
		logic [2:0]  csrOp;        // funct3 of the csr instruction
		logic [11:0] csrAddr;
		logic [31:0] csrData;      // old csr value
		logic [31:0] csrImm;
		logic        csrWe;
		logic        ecall;
		logic        illegal;
		logic        instrMisaligned;
		logic [2:0]  xret;         // mret, sret, uret
	} exeIssue_t;

	typedef struct packed {
		logic [31:0] wbData;
		logic [4:0]  rd;
		logic        we;
		logic [31:0] csrWb;
		logic [11:0] csrAddr;
		logic        csrWe;
		logic [31:0] pc;
	} exeResult_t;

endpackage

`default_nettype wire

// File: trapPkg.sv
`default_nettype none

package trapPkg;

	typedef enum logic [1:0] {
		modeUser    = 2'd0,
		modeSuper   = 2'd1,
		modeMachine = 2'd3
	} mode_e;

	// interrupt codes
	localparam logic [30:0] U_INT_TIMER = 31'd4;
	localparam logic [30:0] S_INT_TIMER = 31'd5;
	localparam logic [30:0] M_INT_TIMER = 31'd7;
	localparam logic [30:0] U_INT_EXT   = 31'd8;
	localparam logic [30:0] S_INT_EXT   = 31'd9;
	localparam logic [30:0] M_INT_EXT   = 31'd11;

	// exception codes
	localparam logic [30:0] I_ADDR_MISALIGNED = 31'd0;
	localparam logic [30:0] I_ILLEGAL         = 31'd2;
	localparam logic [30:0] U_CALL            = 31'd8;   // plus current mode

	typedef struct packed {
		logic        interrupt;
		logic [30:0] code;
	} cause_t;

	typedef struct packed {
		logic mTie;
		logic sTie;
		logic uTie;
		logic mEie;
		logic sEie;
		logic uEie;
	} intEnable_t;

	typedef struct packed {
		logic mTimer;
		logic sTimer;
		logic uTimer;
		logic external;   // one shared external line
	} intLines_t;

	typedef struct packed {
		logic       instrMisaligned;
		logic       ecall;
		logic       illegal;
		logic [2:0] xret;
	} retireFlags_t;

	typedef struct packed {
		logic       exception;
		cause_t     cause;
		logic       mInt;
		logic       sInt;
		logic       uInt;
		logic [2:0] xret;
	} trapInfo_t;

endpackage

`default_nettype wire

// File: issueLatch.sv
`default_nettype none

module issueLatch (
	input  wire logic          clk,
	input  wire logic          nrst,
	input  wire logic          flush,
	input  rvPkg::exeIssue_t   issue,
	output rvPkg::exeIssue_t   stage5
);

	// pipe 5
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			stage5 <= '0;
		end
		else if (flush)
		begin
			stage5 <= '0;   // squash the younger bundle
		end
		else
		begin
			stage5 <= issue;
		end
	end

	// decode must never flag two returns in one bundle
	xretOneHot: assert property (
		@(posedge clk) disable iff (!nrst)
		$onehot0(stage5.xret)
	) else $error("issueLatch: more than one xret bit in pipe 5 (%b)", stage5.xret);

endmodule

`default_nettype wire

// File: aluUnit.sv
`default_nettype none

module aluUnit (
	input  rvPkg::exeIssue_t   stage5,
	output logic [31:0]        aluResult,
	output logic               bjTaken,
	output logic [31:0]        target
);

	import rvPkg::*;

	logic [4:0] shamt;
	logic       branchTaken;

	assign shamt = stage5.opB[4:0];

	always_comb
	begin
		unique case (stage5.aluFn)
			aluAdd:  aluResult = stage5.opA + stage5.opB;
			aluSub:  aluResult = stage5.opA - stage5.opB;
			aluSll:  aluResult = stage5.opA << shamt;
			aluSlt:  aluResult = {31'b0, $signed(stage5.opA) < $signed(stage5.opB)};
			aluSltu: aluResult = {31'b0, stage5.opA < stage5.opB};
			aluXor:  aluResult = stage5.opA ^ stage5.opB;
			aluSrl:  aluResult = stage5.opA >> shamt;
			aluSra:  aluResult = $unsigned($signed(stage5.opA) >>> shamt);
			aluOr:   aluResult = stage5.opA | stage5.opB;
			aluAnd:  aluResult = stage5.opA & stage5.opB;
			default: aluResult = '0;
		endcase
	end

	// beq: sub, taken on zero; bne and blt flip the test with branchNe
	assign branchTaken = stage5.isBranch && ((aluResult == '0) != stage5.branchNe);

	assign bjTaken = branchTaken || stage5.jump || stage5.jumpReg;

	// jalr adds to rs1, everything else is pc relative
	assign target = stage5.jumpReg ? stage5.opA + stage5.imm : stage5.pc + stage5.imm;

endmodule

`default_nettype wire

// File: csrUnit.sv
`default_nettype none

module csrUnit (
	input  rvPkg::exeIssue_t   stage5,
	output logic [31:0]        csrNew
);

	logic [31:0] src;

	// csrrwi/csrrsi/csrrci take the zero-extended uimm
	assign src = stage5.csrOp[2] ? stage5.csrImm : stage5.opA;

	always_comb
	begin
		case (stage5.csrOp[1:0])
			2'd1:    csrNew = src;                       // write
			2'd2:    csrNew = stage5.csrData | src;      // set
			2'd3:    csrNew = stage5.csrData & ~src;     // clear
			default: csrNew = stage5.csrData;            // not a csr op, keep old value
		endcase
	end

endmodule

`default_nettype wire

// File: writebackStage.sv
`default_nettype none

module writebackStage #(
	parameter int linkStep = 1
) (
	input  wire logic             clk,
	input  wire logic             nrst,
	input  wire logic             flush,
	input  rvPkg::exeIssue_t      stage5,
	input  wire logic [31:0]      aluResult,
	input  wire logic [31:0]      csrNew,
	output rvPkg::exeResult_t     result,
	output trapPkg::retireFlags_t retire
);

	import rvPkg::*;
	import trapPkg::*;

	typedef struct packed {
		logic [31:0]  aluRes;
		logic [31:0]  imm;
		logic [31:0]  auipc;
		logic [31:0]  csrOld;    // goes to the register file
		logic [31:0]  csrNew;    // goes to the csr file
		logic [11:0]  csrAddr;
		logic         csrWe;
		logic [4:0]   rd;
		logic         we;
		wbSel_e       wbSel;
		logic [31:0]  pc;
		retireFlags_t retire;
	} pipe6_t;

	pipe6_t p6Next;
	pipe6_t p6;

	always_comb
	begin
		p6Next.aluRes  = aluResult;
		p6Next.imm     = stage5.imm;
		p6Next.auipc   = stage5.pc + stage5.imm;
		p6Next.csrOld  = stage5.csrData;
		p6Next.csrNew  = csrNew;
		p6Next.csrAddr = stage5.csrAddr;
		p6Next.csrWe   = stage5.csrWe;
		p6Next.rd      = stage5.rd;
		p6Next.we      = stage5.we;
		p6Next.wbSel   = stage5.wbSel;
		p6Next.pc      = stage5.pc;
		p6Next.retire  = '{instrMisaligned: stage5.instrMisaligned, ecall: stage5.ecall,
			illegal: stage5.illegal, xret: stage5.xret};
	end

	// pipe 6
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			p6 <= '0;
		end
		else if (flush)
		begin
			p6    <= '0;
			p6.pc <= stage5.pc;   // pc survives the flush
		end
		else
		begin
			p6 <= p6Next;
		end
	end

	always_comb
	begin
		unique case (p6.wbSel)
			wbAlu:   result.wbData = p6.aluRes;
			wbLink:  result.wbData = p6.pc + 32'(linkStep);   // return address
			wbUpper: result.wbData = p6.imm;
			wbAuipc: result.wbData = p6.auipc;
			wbCsr:   result.wbData = p6.csrOld;
			default: result.wbData = '0;
		endcase
	end

	assign result.rd      = p6.rd;
	assign result.we      = p6.we;
	assign result.csrWb   = p6.csrNew;
	assign result.csrAddr = p6.csrAddr;
	assign result.csrWe   = p6.csrWe;
	assign result.pc      = p6.pc;
	assign retire         = p6.retire;

	// an unknown select would silently write zero back
	wbSelLegal: assert property (
		@(posedge clk) disable iff (!nrst)
		p6.wbSel inside {wbAlu, wbLink, wbUpper, wbAuipc, wbCsr}
	) else $error("writebackStage: illegal wbSel %0d in pipe 6", p6.wbSel);

endmodule

`default_nettype wire

// File: trapUnit.sv
`default_nettype none

module trapUnit (
	input  trapPkg::retireFlags_t retire,
	input  trapPkg::mode_e        mode,
	input  trapPkg::intEnable_t   intEn,
	input  trapPkg::intLines_t    intLines,
	output trapPkg::trapInfo_t    trap
);

	import trapPkg::*;

	logic mTimer, sTimer, uTimer;
	logic mExt, sExt, uExt;
	logic anyInt;
	cause_t cause;

	// machine always eligible, supervisor below machine, user only in user mode
	assign mTimer = intEn.mTie && intLines.mTimer;
	assign sTimer = (mode != modeMachine) && intEn.sTie && intLines.sTimer;
	assign uTimer = (mode == modeUser) && intEn.uTie && intLines.uTimer;
	assign mExt   = intEn.mEie && intLines.external;
	assign sExt   = (mode != modeMachine) && intEn.sEie && intLines.external;
	assign uExt   = (mode == modeUser) && intEn.uEie && intLines.external;

	assign anyInt = mTimer || sTimer || uTimer || mExt || sExt || uExt;

	// fixed priority with interrupts ahead of synchronous traps
	always_comb
	begin
		cause           = '0;
		cause.interrupt = anyInt;
		if (mExt)
			cause.code = M_INT_EXT;
		else if (sExt)
			cause.code = S_INT_EXT;
		else if (mTimer)
			cause.code = M_INT_TIMER;
		else if (sTimer)
			cause.code = S_INT_TIMER;
		else if (uExt)
			cause.code = U_INT_EXT;
		else if (uTimer)
			cause.code = U_INT_TIMER;
		else if (retire.instrMisaligned)
			cause.code = I_ADDR_MISALIGNED;
		else if (retire.ecall)
			cause.code = U_CALL + 31'(mode);   // user 8, supervisor 9, machine 11
		else if (retire.illegal)
			cause.code = I_ILLEGAL;
	end

	assign trap.exception = anyInt || retire.instrMisaligned || retire.ecall || retire.illegal
		|| (|retire.xret);
	assign trap.cause = cause;
	assign trap.mInt  = mExt;
	assign trap.sInt  = sExt;
	assign trap.uInt  = uExt;
	assign trap.xret  = retire.xret;

endmodule

`default_nettype wire

// File: exeStage.sv
`default_nettype none

module exeStage #(
	parameter int linkStep = 1   // 1 for word-addressed pc, 4 for byte-addressed
) (
	input  wire logic           clk,
	input  wire logic           nrst,
	input  rvPkg::exeIssue_t    issue,
	input  trapPkg::mode_e      mode,
	input  trapPkg::intEnable_t intEn,
	input  trapPkg::intLines_t  intLines,
	output rvPkg::exeResult_t   result,
	output logic                bjTaken,
	output logic [31:0]         target,
	output trapPkg::trapInfo_t  trap
);

	import rvPkg::*;
	import trapPkg::*;

	exeIssue_t    stage5;
	logic [31:0]  aluResult;
	logic [31:0]  csrNew;
	retireFlags_t retire;
	logic         flush;

	assign flush = trap.exception;   // squashes pipe 5 and pipe 6

	issueLatch issueLatch_i (
		.clk    (clk),
		.nrst   (nrst),
		.flush  (flush),
		.issue  (issue),
		.stage5 (stage5)
	);

	aluUnit aluUnit_i (
		.stage5    (stage5),
		.aluResult (aluResult),
		.bjTaken   (bjTaken),
		.target    (target)
	);

	csrUnit csrUnit_i (
		.stage5 (stage5),
		.csrNew (csrNew)
	);

	writebackStage #(
		.linkStep (linkStep)
	) writebackStage_i (
		.clk       (clk),
		.nrst      (nrst),
		.flush     (flush),
		.stage5    (stage5),
		.aluResult (aluResult),
		.csrNew    (csrNew),
		.result    (result),
		.retire    (retire)
	);

	trapUnit trapUnit_i (
		.retire   (retire),
		.mode     (mode),
		.intEn    (intEn),
		.intLines (intLines),
		.trap     (trap)
	);

endmodule

`default_nettype wire

// File: tbExeStage.sv
`default_nettype none

module tbExeStage;

	import rvPkg::*;
	import trapPkg::*;

	localparam int linkStep = 1;

	// expected contents of pipe 6
	typedef struct packed {
		logic [31:0] aluRes;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] csrOld;
		logic [31:0] csrNew;
		logic [11:0] csrAddr;
		logic        csrWe;
		logic [4:0]  rd;
		logic        we;
		wbSel_e      wbSel;
		logic        instrMisaligned;
		logic        ecall;
		logic        illegal;
		logic [2:0]  xret;
	} modelPipe6_t;

	logic        clk;
	logic        nrst;
	exeIssue_t   issue;
	mode_e       mode;
	intEnable_t  intEn;
	intLines_t   intLines;
	exeResult_t  result;
	logic        bjTaken;
	logic [31:0] target;
	trapInfo_t   trap;

	exeIssue_t   m5;          // model pipe 5
	modelPipe6_t m6;          // model pipe 6
	logic        lastFlush;
	int          errors;
	int          checks;
	int          tests;
	int          syncSeen;
	int          intSeen;

	exeStage #(
		.linkStep (linkStep)
	) exeStage_i (
		.clk      (clk),
		.nrst     (nrst),
		.issue    (issue),
		.mode     (mode),
		.intEn    (intEn),
		.intLines (intLines),
		.result   (result),
		.bjTaken  (bjTaken),
		.target   (target),
		.trap     (trap)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] aluModel(input exeIssue_t b);
		logic [4:0] sh;
		sh = b.opB[4:0];
		case (b.aluFn)
			aluAdd:  return b.opA + b.opB;
			aluSub:  return b.opA - b.opB;
			aluSll:  return b.opA << sh;
			aluSlt:  return ($signed(b.opA) < $signed(b.opB)) ? 32'd1 : 32'd0;
			aluSltu: return (b.opA < b.opB) ? 32'd1 : 32'd0;
			aluXor:  return b.opA ^ b.opB;
			aluSrl:  return b.opA >> sh;
			aluSra:  return 32'($signed(b.opA) >>> sh);
			aluOr:   return b.opA | b.opB;
			aluAnd:  return b.opA & b.opB;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic branchModel(input exeIssue_t b);
		logic taken;
		taken = b.isBranch && ((aluModel(b) == 32'd0) != b.branchNe);
		return taken || b.jump || b.jumpReg;
	endfunction

	function automatic logic [31:0] targetModel(input exeIssue_t b);
		if (b.jumpReg)
			return b.opA + b.imm;
		return b.pc + b.imm;
	endfunction

	function automatic logic [31:0] csrModel(input exeIssue_t b);
		logic [31:0] src;
		src = (b.csrOp >= 3'd5) ? b.csrImm : b.opA;   // immediate forms are 5 to 7
		case (b.csrOp)
			3'd1, 3'd5: return src;
			3'd2, 3'd6: return b.csrData | src;
			3'd3, 3'd7: return b.csrData & ~src;
			default:    return b.csrData;
		endcase
	endfunction

	function automatic modelPipe6_t advance(input exeIssue_t b);
		modelPipe6_t p;
		p.aluRes          = aluModel(b);
		p.imm             = b.imm;
		p.pc              = b.pc;
		p.csrOld          = b.csrData;
		p.csrNew          = csrModel(b);
		p.csrAddr         = b.csrAddr;
		p.csrWe           = b.csrWe;
		p.rd              = b.rd;
		p.we              = b.we;
		p.wbSel           = b.wbSel;
		p.instrMisaligned = b.instrMisaligned;
		p.ecall           = b.ecall;
		p.illegal         = b.illegal;
		p.xret            = b.xret;
		return p;
	endfunction

	function automatic logic [31:0] wbModel(input modelPipe6_t p);
		case (p.wbSel)
			wbAlu:   return p.aluRes;
			wbLink:  return p.pc + 32'(linkStep);
			wbUpper: return p.imm;
			wbAuipc: return p.pc + p.imm;
			wbCsr:   return p.csrOld;
			default: return 32'd0;
		endcase
	endfunction

	function automatic trapInfo_t trapModel(input modelPipe6_t p, input mode_e md,
		input intEnable_t en, input intLines_t ln);
		trapInfo_t t;
		logic mE, sE, uE, mT, sT, uT;
		mE = en.mEie && ln.external;
		sE = (md != modeMachine) && en.sEie && ln.external;
		uE = (md == modeUser) && en.uEie && ln.external;
		mT = en.mTie && ln.mTimer;
		sT = (md != modeMachine) && en.sTie && ln.sTimer;
		uT = (md == modeUser) && en.uTie && ln.uTimer;
		t = '0;
		t.cause.interrupt = mE || sE || mT || sT || uE || uT;
		if (mE)
			t.cause.code = M_INT_EXT;
		else if (sE)
			t.cause.code = S_INT_EXT;
		else if (mT)
			t.cause.code = M_INT_TIMER;
		else if (sT)
			t.cause.code = S_INT_TIMER;
		else if (uE)
			t.cause.code = U_INT_EXT;
		else if (uT)
			t.cause.code = U_INT_TIMER;
		else if (p.instrMisaligned)
			t.cause.code = I_ADDR_MISALIGNED;
		else if (p.ecall)
			t.cause.code = U_CALL + 31'(md);
		else if (p.illegal)
			t.cause.code = I_ILLEGAL;
		t.exception = t.cause.interrupt || p.instrMisaligned || p.ecall || p.illegal
			|| (|p.xret);
		t.mInt = mE;
		t.sInt = sE;
		t.uInt = uE;
		t.xret = p.xret;
		return t;
	endfunction

	function automatic mode_e randomMode();
		int pick;
		pick = $urandom_range(2);
		if (pick == 0)
			return modeUser;
		else if (pick == 1)
			return modeSuper;
		return modeMachine;
	endfunction

	// kind 0 alu, 1 branch/jump, 2 write-back/csr, 3 sync traps, 4 any of them
	function automatic exeIssue_t randomIssue(input int kind);
		exeIssue_t b;
		int sub;
		int pick;
		sub = (kind == 4) ? int'($urandom_range(3)) : kind;
		b = '0;
		b.opA = $urandom;
		b.opB = ($urandom_range(3) == 0) ? b.opA : $urandom;   // equal operands for beq
		b.rd = 5'($urandom);
		b.we = 1'($urandom);
		b.aluFn = aluFn_e'(4'($urandom_range(9)));
		b.wbSel = wbAlu;
		b.imm = $urandom;
		b.pc = $urandom;
		case (sub)
			1:
			begin
				pick = $urandom_range(4);   // beq, bne, blt, jal, jalr
				b.isBranch = (pick < 3);
				b.branchNe = (pick == 1) || (pick == 2);
				b.aluFn = (pick == 2) ? aluSlt : aluSub;
				b.jump = (pick == 3);
				b.jumpReg = (pick == 4);
				b.we = (pick >= 3);
				b.wbSel = (pick >= 3) ? wbLink : wbAlu;
			end
			2:
			begin
				pick = $urandom_range(3);
				b.wbSel = (pick == 0) ? wbLink : (pick == 1) ? wbUpper :
					(pick == 2) ? wbAuipc : wbCsr;
				b.csrOp = 3'($urandom);
				b.csrAddr = 12'($urandom);
				b.csrData = $urandom;
				b.csrImm = 32'($urandom_range(31));
				b.csrWe = (b.csrOp[1:0] != 2'd0);
			end
			3:
			begin
				pick = $urandom_range(7);   // rare enough to let bundles retire
				b.ecall = (pick == 0);
				b.illegal = (pick == 1);
				b.instrMisaligned = (pick == 2);
				if (pick == 3)
					b.xret = 3'(1 << $urandom_range(2));
			end
			default:
			begin
			end
		endcase
		return b;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkResetOutputs();
		compareValue("result.we", 32'(result.we), 32'd0);
		compareValue("result.csrWe", 32'(result.csrWe), 32'd0);
		compareValue("bjTaken", 32'(bjTaken), 32'd0);
		compareValue("trap.exception", 32'(trap.exception), 32'd0);
	endtask

	task automatic checkOutputs();
		trapInfo_t expTrap;
		expTrap = trapModel(m6, mode, intEn, intLines);
		compareValue("result.wbData", result.wbData, wbModel(m6));
		compareValue("result.rd", 32'(result.rd), 32'(m6.rd));
		compareValue("result.we", 32'(result.we), 32'(m6.we));
		compareValue("result.csrWb", result.csrWb, m6.csrNew);
		compareValue("result.csrAddr", 32'(result.csrAddr), 32'(m6.csrAddr));
		compareValue("result.csrWe", 32'(result.csrWe), 32'(m6.csrWe));
		compareValue("result.pc", result.pc, m6.pc);
		compareValue("bjTaken", 32'(bjTaken), 32'(branchModel(m5)));
		compareValue("target", target, targetModel(m5));
		compareValue("trap.exception", 32'(trap.exception), 32'(expTrap.exception));
		compareValue("trap.cause", 32'(trap.cause), 32'(expTrap.cause));
		compareValue("trap.mInt", 32'(trap.mInt), 32'(expTrap.mInt));
		compareValue("trap.sInt", 32'(trap.sInt), 32'(expTrap.sInt));
		compareValue("trap.uInt", 32'(trap.uInt), 32'(expTrap.uInt));
		compareValue("trap.xret", 32'(trap.xret), 32'(expTrap.xret));
		checks++;
		if (lastFlush && (result.we || result.csrWe))
		begin
			errors++;
			$display("write enable still high on the cycle after an exception at %0t", $time);
		end
		if (expTrap.cause.interrupt)
			intSeen++;
		else if (m6.ecall || m6.illegal || m6.instrMisaligned)
			syncSeen++;
	endtask

	// advance the model on the edge, drive the next inputs, check at negedge
	task automatic stepCycle(input exeIssue_t nextIssue, input mode_e nextMode,
		input intEnable_t nextEn, input intLines_t nextLines);
		trapInfo_t edgeTrap;
		@(posedge clk);
		edgeTrap = trapModel(m6, mode, intEn, intLines);
		if (edgeTrap.exception)
		begin
			m6 = '0;
			m6.pc = m5.pc;
			m5 = '0;
		end
		else
		begin
			m6 = advance(m5);
			m5 = issue;
		end
		lastFlush = edgeTrap.exception;
		issue <= nextIssue;
		mode <= nextMode;
		intEn <= nextEn;
		intLines <= nextLines;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic runTest(input string name, input int kind, input int minCycles,
		input int minEvents, input int limit);
		int startErrors;
		int startEvents;
		int events;
		int n;
		intEnable_t en;
		intLines_t ln;
		startErrors = errors;
		startEvents = (kind == 4) ? intSeen : syncSeen;
		events = 0;
		n = 0;
		while ((n < minCycles || events < minEvents) && n < limit)
		begin
			en = '0;
			ln = '0;
			if (kind == 4)
			begin
				en = 6'($urandom);
				ln.mTimer = ($urandom_range(3) == 0);
				ln.sTimer = ($urandom_range(3) == 0);
				ln.uTimer = ($urandom_range(3) == 0);
				ln.external = ($urandom_range(3) == 0);
			end
			stepCycle(randomIssue(kind), randomMode(), en, ln);
			n++;
			events = ((kind == 4) ? intSeen : syncSeen) - startEvents;
		end
		if (events < minEvents)
		begin
			errors++;
			$display("%s timed out with only %0d events after %0d cycles", name, events, n);
		end
		// drain both pipe registers with idle bundles
		stepCycle('0, modeUser, '0, '0);
		stepCycle('0, modeUser, '0, '0);
		tests++;
		$display("test %0d %s: %0d cycles, %0d errors", tests, name, n, errors - startErrors);
	endtask

	initial
	begin
		int i;
		int startErrors;
		void'($urandom(43));
		clk = 1'b0;
		nrst = 1'b0;
		issue = '0;
		mode = modeUser;
		intEn = '0;
		intLines = '0;
		m5 = '0;
		m6 = '0;
		lastFlush = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		syncSeen = 0;
		intSeen = 0;

		startErrors = errors;
		for (i = 0; i < 3; i++)
		begin
			@(posedge clk);
			if (i == 2)
				nrst <= 1'b1;
			@(negedge clk);
			checkResetOutputs();   // last pass is the first cycle out of reset
		end
		tests++;
		$display("test %0d reset: 3 cycles, %0d errors", tests, errors - startErrors);

		runTest("alu results", 0, 200, 0, 200);
		runTest("branches and jumps", 1, 200, 0, 200);
		runTest("write-back select and csr", 2, 200, 0, 200);
		runTest("synchronous traps", 3, 100, 20, 3000);
		runTest("interrupts", 4, 200, 40, 3000);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
rvPkg.sv
trapPkg.sv
issueLatch.sv
aluUnit.sv
csrUnit.sv
writebackStage.sv
trapUnit.sv
exeStage.sv
tbExeStage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbExeStage
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?=
PASS_TEXT := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
